// File: bench/tb_clk_gen.sv
// ========================================
// testbench clocks: 20 ns bus clock, 14 ns
// and 60 ns kernel sources, power-on reset
// ========================================
`timescale 1ns/1ps

module tb_clk_gen (
  output logic       bus_clk,
  output logic [1:0] ker_clks,
  output logic       rst_n
);

  logic clk_fast;
  logic clk_slow;

  assign ker_clks = {clk_slow, clk_fast};

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;
  end

  initial begin
    clk_fast = 1'b0;
    #1;  // keeps edges off the bus clock grid
    forever #7 clk_fast = ~clk_fast;
  end

  initial begin
    clk_slow = 1'b0;
    forever #30 clk_slow = ~clk_slow;
  end

  // reset held for 5 bus cycles
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge bus_clk);
    #2 rst_n = 1'b1;
  end

endmodule

// File: bench/tb_rcc_per_top.sv
// ========================================
// testbench for rcc_per_top: random
// stimulus, reference model, edge counting
// of the gated clocks, watchdog
// ========================================
`timescale 1ns/1ps

module tb_rcc_per_top;

  localparam int DRV         = 2;  // drive delay after the bus edge
  localparam int CLK_PERIOD  = 20;
  localparam int NUM_TESTS   = 6;
  localparam int TRIALS      = 12;
  localparam int TIMEOUT_NS  = NUM_TESTS * TRIALS * 20 * CLK_PERIOD * 2;
  localparam int UART_DELAY  = 2;
  localparam int LPTIM_DELAY = 4;

  // kernel source codes
  localparam logic [2:0] SEL_HSI = 3'd1;
  localparam logic [2:0] SEL_CSI = 3'd2;
  localparam logic [2:0] SEL_LSE = 3'd3;
  localparam logic [2:0] SEL_LSI = 3'd4;

  logic       bus_clk;
  logic [1:0] ker_clks;
  logic       gen_rst_n;
  logic       rst_n;
  logic       sys_rst_n;
  logic       testmode;
  logic       arcg_on;
  logic       d2_rst_n;
  logic       d3_rst_n;
  logic       c1_sleep;
  logic       c1_deepsleep;
  logic       c2_sleep;
  logic       c2_deepsleep;
  logic       d3_deepsleep;
  logic [4:0] uart_rcc_en;
  logic [2:0] uart_ker_sel;
  logic       uart_ker_req;
  logic       uart_sft_rst_n;
  logic [4:0] lptim_rcc_en;
  logic [2:0] lptim_ker_sel;
  logic       lptim_ker_req;
  logic       lptim_sft_rst_n;
  logic       uart_bus_clk;
  logic [1:0] uart_ker_clks;
  logic       uart_rst_n;
  logic       lptim_bus_clk;
  logic [1:0] lptim_ker_clks;
  logic       lptim_rst_n;
  logic       hsi_ker_clk_req;
  logic       csi_ker_clk_req;

  // model outputs
  logic exp_uart_bus;
  logic exp_uart_ker;
  logic exp_lptim_bus;
  logic exp_lptim_ker;
  logic exp_hsi;
  logic exp_csi;

  logic [31:0] lfsr = 32'hc16c_7d49;
  int          test_errs = 0;
  int          err_total = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int unsigned n_ub = 0;
  int unsigned n_uk0 = 0;
  int unsigned n_uk1 = 0;
  int unsigned n_lb = 0;
  int unsigned n_lk0 = 0;
  int unsigned n_lk1 = 0;

  assign rst_n = gen_rst_n & sys_rst_n;

  tb_clk_gen clk_gen0 (
    .bus_clk (bus_clk),
    .ker_clks(ker_clks),
    .rst_n   (gen_rst_n)
  );

  rcc_per_top dut0 (
    .bus_clk        (bus_clk),
    .rst_n          (rst_n),
    .ker_src_clks   (ker_clks),
    .testmode       (testmode),
    .arcg_on        (arcg_on),
    .d2_rst_n       (d2_rst_n),
    .d3_rst_n       (d3_rst_n),
    .c1_sleep       (c1_sleep),
    .c1_deepsleep   (c1_deepsleep),
    .c2_sleep       (c2_sleep),
    .c2_deepsleep   (c2_deepsleep),
    .d3_deepsleep   (d3_deepsleep),
    .uart_rcc_en    (uart_rcc_en),
    .uart_ker_sel   (uart_ker_sel),
    .uart_ker_req   (uart_ker_req),
    .uart_sft_rst_n (uart_sft_rst_n),
    .lptim_rcc_en   (lptim_rcc_en),
    .lptim_ker_sel  (lptim_ker_sel),
    .lptim_ker_req  (lptim_ker_req),
    .lptim_sft_rst_n(lptim_sft_rst_n),
    .uart_bus_clk   (uart_bus_clk),
    .uart_ker_clks  (uart_ker_clks),
    .uart_rst_n     (uart_rst_n),
    .lptim_bus_clk  (lptim_bus_clk),
    .lptim_ker_clks (lptim_ker_clks),
    .lptim_rst_n    (lptim_rst_n),
    .hsi_ker_clk_req(hsi_ker_clk_req),
    .csi_ker_clk_req(csi_ker_clk_req)
  );

  // rising edges of every gated clock
  always @(posedge uart_bus_clk) n_ub++;
  always @(posedge uart_ker_clks[0]) n_uk0++;
  always @(posedge uart_ker_clks[1]) n_uk1++;
  always @(posedge lptim_bus_clk) n_lb++;
  always @(posedge lptim_ker_clks[0]) n_lk0++;
  always @(posedge lptim_ker_clks[1]) n_lk1++;

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_equal(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    err_total += test_errs;
    $display("test %0d %s: %s, %0d mismatches", tests_run, name,
             (test_errs == 0) ? "ok" : "FAIL", test_errs);
    test_errs = 0;
  endtask

  task automatic drive_idle;
    sys_rst_n       = 1'b1;
    testmode        = 1'b0;
    arcg_on         = 1'b0;
    d2_rst_n        = 1'b1;
    d3_rst_n        = 1'b1;
    {c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep} = 5'b0;
    uart_rcc_en     = 5'b0;
    uart_ker_sel    = 3'd0;
    uart_ker_req    = 1'b0;
    uart_sft_rst_n  = 1'b1;
    lptim_rcc_en    = 5'b0;
    lptim_ker_sel   = 3'd0;
    lptim_ker_req   = 1'b0;
    lptim_sft_rst_n = 1'b1;
  endtask

  task automatic randomize_inputs;
    logic [31:0] r;
    r = rand_bits(5);
    uart_rcc_en = r[4:0];
    r = rand_bits(5);
    lptim_rcc_en = r[4:0];
    r = rand_bits(5);
    {c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep} = r[4:0];
    r = rand_bits(3) % 5;  // valid source codes only
    uart_ker_sel = r[2:0];
    r = rand_bits(3) % 5;
    lptim_ker_sel = r[2:0];
    r = rand_bits(2);
    uart_ker_req  = r[0];
    lptim_ker_req = r[1];
  endtask

  // enable rules, valid while arcg_on is low
  task automatic compute_expected;
    logic u_c1;
    logic u_c2;
    logic l_c1;
    logic l_c2;
    logic l_d3;
    logic u_ok;
    logic l_ok;
    u_ok = sys_rst_n & gen_rst_n & d2_rst_n & uart_sft_rst_n;
    l_ok = sys_rst_n & gen_rst_n & d3_rst_n & lptim_sft_rst_n;
    u_c1 = uart_rcc_en[0] & (~c1_sleep | uart_rcc_en[1]) & ~c1_deepsleep;
    u_c2 = uart_rcc_en[2] & (~c2_sleep | uart_rcc_en[3]) & ~c2_deepsleep;
    l_c1 = ~c1_deepsleep;  // owned by CPU1, no lpen
    l_c2 = lptim_rcc_en[2] & ~c2_deepsleep;
    l_d3 = lptim_rcc_en[4] & ~d3_deepsleep;
    exp_hsi       = (uart_ker_sel == SEL_HSI) & uart_ker_req;
    exp_csi       = (uart_ker_sel == SEL_CSI) & uart_ker_req;
    exp_uart_bus  = (u_c1 | u_c2) & u_ok;
    exp_uart_ker  = (exp_uart_bus | exp_hsi | exp_csi) & u_ok;
    exp_lptim_bus = (l_c1 | l_c2 | l_d3) & l_ok;
    exp_lptim_ker = (exp_lptim_bus | (lptim_ker_sel == SEL_LSE)
                    | (lptim_ker_sel == SEL_LSI)) & l_ok;
  endtask

  // 8 cycles to settle, then a 10 cycle counting window
  task automatic measure_clocks(output logic [5:0] running);
    int unsigned s [6];
    repeat (8) @(posedge bus_clk);
    #5;
    s = '{n_ub, n_uk0, n_uk1, n_lb, n_lk0, n_lk1};
    repeat (10) @(posedge bus_clk);
    #5;
    running = {n_lk1 != s[5], n_lk0 != s[4], n_lb != s[3],
               n_uk1 != s[2], n_uk0 != s[1], n_ub != s[0]};
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, tests did not complete", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [5:0]  run;
    int unsigned s_ub;
    int unsigned s_lb;
    drive_idle();
    wait (gen_rst_n);
    repeat (3) @(posedge bus_clk);

    for (int t = 0; t < TRIALS; t++) begin
      @(posedge bus_clk);
      #DRV;
      r = rand_bits(5);
      {sys_rst_n, d2_rst_n, d3_rst_n, uart_sft_rst_n, lptim_sft_rst_n} = r[4:0];
      #1;
      check_equal("uart_rst_n", uart_rst_n, sys_rst_n & d2_rst_n & uart_sft_rst_n);
      check_equal("lptim_rst_n", lptim_rst_n, sys_rst_n & d3_rst_n & lptim_sft_rst_n);
    end
    @(posedge bus_clk);
    #DRV;
    {sys_rst_n, d2_rst_n, d3_rst_n, uart_sft_rst_n, lptim_sft_rst_n} = 5'b11111;
    finish_test("resets");

    for (int t = 0; t < TRIALS; t++) begin
      @(posedge bus_clk);
      #DRV;
      randomize_inputs();
      compute_expected();
      measure_clocks(run);
      check_equal("uart_bus_clk", run[0], exp_uart_bus);
      check_equal("lptim_bus_clk", run[3], exp_lptim_bus);
    end
    finish_test("bus clocks");

    for (int t = 0; t < TRIALS; t++) begin
      @(posedge bus_clk);
      #DRV;
      randomize_inputs();
      if (t < 2) begin  // lptim on LSE/LSI through full deepsleep
        {c1_deepsleep, c2_deepsleep, d3_deepsleep} = 3'b111;
        lptim_ker_sel = (t == 0) ? SEL_LSE : SEL_LSI;
      end
      compute_expected();
      measure_clocks(run);
      check_equal("uart_ker_clks[0]", run[1], exp_uart_ker);
      check_equal("uart_ker_clks[1]", run[2], exp_uart_ker);
      check_equal("lptim_ker_clks[0]", run[4], exp_lptim_ker);
      check_equal("lptim_ker_clks[1]", run[5], exp_lptim_ker);
    end
    finish_test("kernel clocks");

    for (int t = 0; t < TRIALS; t++) begin
      @(posedge bus_clk);
      #DRV;
      randomize_inputs();
      #1;
      compute_expected();
      check_equal("hsi_ker_clk_req", hsi_ker_clk_req, exp_hsi);
      check_equal("csi_ker_clk_req", csi_ker_clk_req, exp_csi);
    end
    finish_test("osc requests");

    @(posedge bus_clk);
    #DRV;
    arcg_on = 1'b1;
    for (int t = 0; t < TRIALS; t++) begin
      @(posedge bus_clk);
      #DRV;
      r = rand_bits(5);
      uart_rcc_en = r[4:0] | 5'b00001;  // CPU1 enable keeps the bus term on
      {c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep} = 5'b0;
      uart_sft_rst_n  = 1'b0;
      lptim_sft_rst_n = 1'b0;
      #1;
      s_ub = n_ub;
      s_lb = n_lb;
      repeat (3) @(posedge bus_clk);
      #DRV;
      check_equal("uart_bus_clk in reset", n_ub != s_ub, 1'b0);
      check_equal("lptim_bus_clk in reset", n_lb != s_lb, 1'b0);
      uart_sft_rst_n  = 1'b1;
      lptim_sft_rst_n = 1'b1;
      s_ub = n_ub;
      s_lb = n_lb;
      for (int k = 1; k < LPTIM_DELAY; k++) begin
        @(posedge bus_clk);
        #5;
        if (k < UART_DELAY) check_equal("uart_bus_clk hold-off", n_ub != s_ub, 1'b0);
        check_equal("lptim_bus_clk hold-off", n_lb != s_lb, 1'b0);
      end
      measure_clocks(run);
      check_equal("uart_bus_clk after hold-off", run[0], 1'b1);
      check_equal("lptim_bus_clk after hold-off", run[3], 1'b1);
    end
    @(posedge bus_clk);
    #DRV;
    arcg_on = 1'b0;
    finish_test("hold-off");

    for (int t = 0; t < TRIALS; t++) begin
      @(posedge bus_clk);
      #DRV;
      testmode = 1'b1;
      randomize_inputs();
      r = rand_bits(5);
      {sys_rst_n, d2_rst_n, d3_rst_n, uart_sft_rst_n, lptim_sft_rst_n} = r[4:0];
      measure_clocks(run);
      check_equal("uart_bus_clk", run[0], 1'b1);
      check_equal("uart_ker_clks[0]", run[1], 1'b1);
      check_equal("uart_ker_clks[1]", run[2], 1'b1);
      check_equal("lptim_bus_clk", run[3], 1'b1);
      check_equal("lptim_ker_clks[0]", run[4], 1'b1);
      check_equal("lptim_ker_clks[1]", run[5], 1'b1);
    end
    @(posedge bus_clk);
    #DRV;
    drive_idle();
    finish_test("test mode");

    $display("counts: %0d tests, %0d failed, %0d mismatches",
             tests_run, tests_failed, err_total);
    if (err_total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: design/arcg_release_timer.sv
// ======================================
// peripheral reset combining and the
// clock hold-off counter after release
// ======================================
`timescale 1ns/1ps

module arcg_release_timer #(
  parameter int CLK_ON_DELAY = 2
) (
  input  logic bus_clk,
  input  logic rst_n,
  input  logic dom_rst_n,
  input  logic sft_rst_n,
  input  logic arcg_on,
  output logic per_rst_n,
  output logic arcg_clk_en
);

  localparam int CNT_W = $clog2(CLK_ON_DELAY + 1);

  rcc_pwr_pkg::arcg_state_e state;
  logic [CNT_W-1:0]         cnt;  // bus edges seen since release

  // no clock involved, asserts and releases immediately
  assign per_rst_n = rst_n & dom_rst_n & sft_rst_n;

  always_ff @(posedge bus_clk or negedge per_rst_n) begin
    if (!per_rst_n) begin
      state <= rcc_pwr_pkg::ARCG_HOLD;
      cnt   <= '0;
    end else begin
      case (state)
        rcc_pwr_pkg::ARCG_HOLD: begin  // first edge after release
          cnt <= CNT_W'(1);
          if (CLK_ON_DELAY <= 1) state <= rcc_pwr_pkg::ARCG_RUN;
          else state <= rcc_pwr_pkg::ARCG_COUNT;
        end
        rcc_pwr_pkg::ARCG_COUNT: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(CLK_ON_DELAY - 1)) state <= rcc_pwr_pkg::ARCG_RUN;
        end
        default: state <= rcc_pwr_pkg::ARCG_RUN;
      endcase
    end
  end

  // without arcg the clocks simply follow the reset
  assign arcg_clk_en = arcg_on ? (state == rcc_pwr_pkg::ARCG_RUN) : per_rst_n;

  // clocks come back only after the full hold-off
  a_full_hold_off: assert property (
    @(posedge bus_clk) disable iff (!per_rst_n || !arcg_on)
      $rose(arcg_clk_en) |-> $past(per_rst_n, CLK_ON_DELAY)
  ) else $error("arcg_clk_en rose before the hold-off ended");

endmodule

// File: design/bus_clk_gating.sv
// ======================================
// latch-based bus clock gate with
// test bypass
// ======================================
`timescale 1ns/1ps

module bus_clk_gating (
  input  logic    raw_clk,
  per_clk_if.gate clk,
  output logic    gen_clk
);

  logic en_lat;

  // transparent in the low phase, so no runt pulses
  always_latch begin
    if (!clk.per_rst_n) en_lat <= 1'b0;
    else if (!raw_clk) en_lat <= clk.bus_clk_en;
  end

  assign gen_clk = clk.testmode ? raw_clk : (raw_clk & en_lat);

  // sampled at the end of each high phase
  a_quiet_in_reset: assert property (
    @(negedge raw_clk) (!clk.per_rst_n && !clk.testmode) |-> !gen_clk
  ) else $error("bus clock pulse during peripheral reset");

endmodule

// File: design/per_clk_en_decode.sv
// ======================================
// bus and kernel clock enable decode,
// HSI / CSI oscillator requests
// ======================================
`timescale 1ns/1ps

module per_clk_en_decode #(
  parameter rcc_pwr_pkg::domain_e DOMAIN = rcc_pwr_pkg::DOM_D1,
  parameter bit SUPPORT_LPEN     = 1'b0,
  parameter bit SUPPORT_AMEN     = 1'b0,
  parameter bit ASSIGNED_TO_CPU1 = 1'b0,
  parameter bit ASSIGNED_TO_CPU2 = 1'b0,
  parameter logic [rcc_clk_pkg::KER_MSK_W-1:0] KER_SRC_MASK = '0
) (
  input  logic [rcc_pwr_pkg::RCC_EN_W-1:0] rcc_en,
  input  rcc_clk_pkg::ker_src_e            ker_sel,
  input  logic                             ker_req,
  input  logic                             arcg_clk_en,
  pwr_status_if.mon                        pwr,
  per_clk_if.dec                           clk,
  output logic                             hsi_req,
  output logic                             csi_req
);

  logic c1_lp_ok;
  logic c2_lp_ok;
  logic c1_term;
  logic c2_term;
  logic d3_term;
  logic bus_en;
  logic lse_sel;
  logic lsi_sel;

  // sleep only stops the clock unless lpen is set
  if (SUPPORT_LPEN) begin : g_lpen
    assign c1_lp_ok = ~pwr.c1_sleep | rcc_en[rcc_pwr_pkg::LPEN_C1];
    assign c2_lp_ok = ~pwr.c2_sleep | rcc_en[rcc_pwr_pkg::LPEN_C2];
  end else begin : g_no_lpen
    assign c1_lp_ok = 1'b1;
    assign c2_lp_ok = 1'b1;
  end

  assign c1_term = (rcc_en[rcc_pwr_pkg::EN_C1] | ASSIGNED_TO_CPU1) & c1_lp_ok
                   & ~pwr.c1_deepsleep;
  assign c2_term = (rcc_en[rcc_pwr_pkg::EN_C2] | ASSIGNED_TO_CPU2) & c2_lp_ok
                   & ~pwr.c2_deepsleep;

  if (DOMAIN == rcc_pwr_pkg::DOM_D3) begin : g_d3
    if (SUPPORT_AMEN) begin : g_amen
      assign d3_term = rcc_en[rcc_pwr_pkg::AMEN] & ~pwr.d3_deepsleep;
    end else begin : g_no_amen
      assign d3_term = ~pwr.d3_deepsleep;  // clocked while D3 is awake
    end
  end else begin : g_not_d3
    assign d3_term = 1'b0;
  end

  assign bus_en = (c1_term | c2_term | d3_term) & arcg_clk_en;

  // HSI/CSI only on an active kernel request
  assign hsi_req = KER_SRC_MASK[rcc_clk_pkg::KS_HSI] & (ker_sel == rcc_clk_pkg::KS_HSI)
                   & ker_req;
  assign csi_req = KER_SRC_MASK[rcc_clk_pkg::KS_CSI] & (ker_sel == rcc_clk_pkg::KS_CSI)
                   & ker_req;
  assign lse_sel = KER_SRC_MASK[rcc_clk_pkg::KS_LSE] & (ker_sel == rcc_clk_pkg::KS_LSE);
  assign lsi_sel = KER_SRC_MASK[rcc_clk_pkg::KS_LSI] & (ker_sel == rcc_clk_pkg::KS_LSI);

  assign clk.bus_clk_en = bus_en;
  assign clk.ker_clk_en = (bus_en | hsi_req | csi_req | lse_sel | lsi_sel) & arcg_clk_en;

endmodule

// File: design/per_ker_clk_rst_control.sv
// ======================================
// clock and reset control for one
// peripheral: reset, hold-off, enable
// decode, bus and kernel clock gates
// ======================================
`timescale 1ns/1ps

module per_ker_clk_rst_control #(
  parameter rcc_pwr_pkg::domain_e DOMAIN = rcc_pwr_pkg::DOM_D1,
  parameter bit SUPPORT_LPEN     = 1'b0,
  parameter bit SUPPORT_AMEN     = 1'b0,
  parameter bit ASSIGNED_TO_CPU1 = 1'b0,
  parameter bit ASSIGNED_TO_CPU2 = 1'b0,
  parameter logic [rcc_clk_pkg::KER_MSK_W-1:0] KER_SRC_MASK = '0,
  parameter int CLK_ON_DELAY     = 2
) (
  input  logic                                bus_clk,
  input  logic [rcc_clk_pkg::KER_SRC_NUM-1:0] ker_src_clks,
  input  logic                                rst_n,
  input  logic                                dom_rst_n,
  input  logic                                sft_rst_n,
  input  logic                                arcg_on,
  input  logic                                testmode,
  input  logic [rcc_pwr_pkg::RCC_EN_W-1:0]    rcc_en,
  input  rcc_clk_pkg::ker_src_e               ker_sel,
  input  logic                                ker_req,
  pwr_status_if.mon                           pwr,
  output logic                                per_bus_clk,
  output logic [rcc_clk_pkg::KER_SRC_NUM-1:0] per_ker_clks,
  output logic                                per_rst_n,
  output logic                                hsi_req,
  output logic                                csi_req
);

  per_clk_if clk_if ();
  logic      arcg_clk_en;

  arcg_release_timer #(
    .CLK_ON_DELAY(CLK_ON_DELAY)
  ) u_release (
    .bus_clk    (bus_clk),
    .rst_n      (rst_n),
    .dom_rst_n  (dom_rst_n),
    .sft_rst_n  (sft_rst_n),
    .arcg_on    (arcg_on),
    .per_rst_n  (per_rst_n),
    .arcg_clk_en(arcg_clk_en)
  );

  assign clk_if.per_rst_n = per_rst_n;
  assign clk_if.testmode  = testmode;  // bypasses every gate

  per_clk_en_decode #(
    .DOMAIN          (DOMAIN),
    .SUPPORT_LPEN    (SUPPORT_LPEN),
    .SUPPORT_AMEN    (SUPPORT_AMEN),
    .ASSIGNED_TO_CPU1(ASSIGNED_TO_CPU1),
    .ASSIGNED_TO_CPU2(ASSIGNED_TO_CPU2),
    .KER_SRC_MASK    (KER_SRC_MASK)
  ) u_decode (
    .rcc_en     (rcc_en),
    .ker_sel    (ker_sel),
    .ker_req    (ker_req),
    .arcg_clk_en(arcg_clk_en),
    .pwr        (pwr),
    .clk        (clk_if),
    .hsi_req    (hsi_req),
    .csi_req    (csi_req)
  );

  bus_clk_gating u_bus_gate (
    .raw_clk(bus_clk),
    .clk    (clk_if),
    .gen_clk(per_bus_clk)
  );

  for (genvar i = 0; i < rcc_clk_pkg::KER_SRC_NUM; i++) begin : g_ker_gate
    rst_sync_clk_gating u_ker_gate (
      .raw_clk(ker_src_clks[i]),
      .clk    (clk_if),
      .gen_clk(per_ker_clks[i])
    );
  end

endmodule

// File: design/rcc_clk_pkg.sv
// ======================================
// clock-tree definitions for the RCC
// peripheral slice: kernel source codes,
// select width, source masks
// ======================================
package rcc_clk_pkg;

  // width of a kernel select field
  localparam int KER_SEL_W = 3;

  // kernel source clocks gated per peripheral
  localparam int KER_SRC_NUM = 2;

  // one mask bit per source code
  localparam int KER_MSK_W = 5;

  // kernel source select codes, also the mask bit positions
  typedef enum logic [KER_SEL_W-1:0] {
    KS_PCLK = 3'd0,
    KS_HSI  = 3'd1,
    KS_CSI  = 3'd2,
    KS_LSE  = 3'd3,
    KS_LSI  = 3'd4
  } ker_src_e;

  // sources each peripheral may request
  localparam logic [KER_MSK_W-1:0] UART_SRC_MASK =
    (KER_MSK_W'(1) << KS_HSI) | (KER_MSK_W'(1) << KS_CSI);
  localparam logic [KER_MSK_W-1:0] LPTIM_SRC_MASK =
    (KER_MSK_W'(1) << KS_LSE) | (KER_MSK_W'(1) << KS_LSI);

endpackage

// File: design/rcc_ifs.sv
// ======================================
// pwr_status_if: CPU and D3 sleep states
// per_clk_if: per-peripheral enables,
// reset and test bypass
// ======================================
`timescale 1ns/1ps

interface pwr_status_if;
  logic c1_sleep;
  logic c1_deepsleep;
  logic c2_sleep;
  logic c2_deepsleep;
  logic d3_deepsleep;

  modport src (output c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep);
  modport mon (input c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep);
endinterface

interface per_clk_if;
  logic bus_clk_en;
  logic ker_clk_en;
  logic per_rst_n;
  logic testmode;

  modport ctl (output per_rst_n, testmode, input bus_clk_en, ker_clk_en);
  modport dec (output bus_clk_en, ker_clk_en);
  modport gate (input bus_clk_en, ker_clk_en, per_rst_n, testmode);
endinterface

// File: design/rcc_per_top.sv
// ======================================
// RCC peripheral slice top: uart in D2,
// lptim in D3, shared sleep status
// ======================================
`timescale 1ns/1ps

module rcc_per_top (
  input  logic                                bus_clk,
  input  logic                                rst_n,
  input  logic [rcc_clk_pkg::KER_SRC_NUM-1:0] ker_src_clks,
  input  logic                                testmode,
  input  logic                                arcg_on,
  input  logic                                d2_rst_n,
  input  logic                                d3_rst_n,
  input  logic                                c1_sleep,
  input  logic                                c1_deepsleep,
  input  logic                                c2_sleep,
  input  logic                                c2_deepsleep,
  input  logic                                d3_deepsleep,
  input  logic [rcc_pwr_pkg::RCC_EN_W-1:0]    uart_rcc_en,
  input  logic [rcc_clk_pkg::KER_SEL_W-1:0]   uart_ker_sel,
  input  logic                                uart_ker_req,
  input  logic                                uart_sft_rst_n,
  input  logic [rcc_pwr_pkg::RCC_EN_W-1:0]    lptim_rcc_en,
  input  logic [rcc_clk_pkg::KER_SEL_W-1:0]   lptim_ker_sel,
  input  logic                                lptim_ker_req,
  input  logic                                lptim_sft_rst_n,
  output logic                                uart_bus_clk,
  output logic [rcc_clk_pkg::KER_SRC_NUM-1:0] uart_ker_clks,
  output logic                                uart_rst_n,
  output logic                                lptim_bus_clk,
  output logic [rcc_clk_pkg::KER_SRC_NUM-1:0] lptim_ker_clks,
  output logic                                lptim_rst_n,
  output logic                                hsi_ker_clk_req,
  output logic                                csi_ker_clk_req
);

  pwr_status_if pwr_if ();

  assign pwr_if.c1_sleep     = c1_sleep;
  assign pwr_if.c1_deepsleep = c1_deepsleep;
  assign pwr_if.c2_sleep     = c2_sleep;
  assign pwr_if.c2_deepsleep = c2_deepsleep;
  assign pwr_if.d3_deepsleep = d3_deepsleep;

  // uart: D2, low-power enable, HSI/CSI kernel
  per_ker_clk_rst_control #(
    .DOMAIN          (rcc_pwr_pkg::DOM_D2),
    .SUPPORT_LPEN    (1'b1),
    .SUPPORT_AMEN    (1'b0),
    .ASSIGNED_TO_CPU1(1'b0),
    .ASSIGNED_TO_CPU2(1'b0),
    .KER_SRC_MASK    (rcc_clk_pkg::UART_SRC_MASK),
    .CLK_ON_DELAY    (rcc_pwr_pkg::UART_CLK_ON_DELAY)
  ) u_uart (
    .bus_clk     (bus_clk),
    .ker_src_clks(ker_src_clks),
    .rst_n       (rst_n),
    .dom_rst_n   (d2_rst_n),
    .sft_rst_n   (uart_sft_rst_n),
    .arcg_on     (arcg_on),
    .testmode    (testmode),
    .rcc_en      (uart_rcc_en),
    .ker_sel     (rcc_clk_pkg::ker_src_e'(uart_ker_sel)),
    .ker_req     (uart_ker_req),
    .pwr         (pwr_if),
    .per_bus_clk (uart_bus_clk),
    .per_ker_clks(uart_ker_clks),
    .per_rst_n   (uart_rst_n),
    .hsi_req     (hsi_ker_clk_req),
    .csi_req     (csi_ker_clk_req)
  );

  // lptim: D3 autonomous, owned by CPU1, LSE/LSI kernel
  per_ker_clk_rst_control #(
    .DOMAIN          (rcc_pwr_pkg::DOM_D3),
    .SUPPORT_LPEN    (1'b0),
    .SUPPORT_AMEN    (1'b1),
    .ASSIGNED_TO_CPU1(1'b1),
    .ASSIGNED_TO_CPU2(1'b0),
    .KER_SRC_MASK    (rcc_clk_pkg::LPTIM_SRC_MASK),
    .CLK_ON_DELAY    (rcc_pwr_pkg::LPTIM_CLK_ON_DELAY)
  ) u_lptim (
    .bus_clk     (bus_clk),
    .ker_src_clks(ker_src_clks),
    .rst_n       (rst_n),
    .dom_rst_n   (d3_rst_n),
    .sft_rst_n   (lptim_sft_rst_n),
    .arcg_on     (arcg_on),
    .testmode    (testmode),
    .rcc_en      (lptim_rcc_en),
    .ker_sel     (rcc_clk_pkg::ker_src_e'(lptim_ker_sel)),
    .ker_req     (lptim_ker_req),
    .pwr         (pwr_if),
    .per_bus_clk (lptim_bus_clk),
    .per_ker_clks(lptim_ker_clks),
    .per_rst_n   (lptim_rst_n),
    .hsi_req     (),  // no HSI/CSI sources
    .csi_req     ()
  );

endmodule

// File: design/rcc_pwr_pkg.sv
// ======================================
// power-side definitions: domains,
// RCC enable bit positions, release
// timer states and hold-off delays
// ======================================
package rcc_pwr_pkg;

  typedef enum logic [1:0] {
    DOM_D1 = 2'd0,
    DOM_D2 = 2'd1,
    DOM_D3 = 2'd2
  } domain_e;

  // per-peripheral RCC enable field
  localparam int RCC_EN_W = 5;
  localparam int EN_C1    = 0;
  localparam int LPEN_C1  = 1;
  localparam int EN_C2    = 2;
  localparam int LPEN_C2  = 3;
  localparam int AMEN     = 4;  // autonomous mode, D3 only

  typedef enum logic [1:0] {
    ARCG_HOLD  = 2'd0,
    ARCG_COUNT = 2'd1,
    ARCG_RUN   = 2'd2
  } arcg_state_e;

  // bus cycles of clock hold-off after reset release
  localparam int UART_CLK_ON_DELAY  = 2;
  localparam int LPTIM_CLK_ON_DELAY = 4;

endpackage

// File: design/rst_sync_clk_gating.sv
// ======================================
// kernel clock gate, enable resynced
// into the kernel clock domain
// ======================================
`timescale 1ns/1ps

module rst_sync_clk_gating (
  input  logic    raw_clk,
  per_clk_if.gate clk,
  output logic    gen_clk
);

  logic sync_meta;
  logic sync_en;
  logic en_lat;

  // enable comes from the bus clock domain
  always_ff @(posedge raw_clk or negedge clk.per_rst_n) begin
    if (!clk.per_rst_n) begin
      sync_meta <= 1'b0;
      sync_en   <= 1'b0;
    end else begin
      sync_meta <= clk.ker_clk_en;
      sync_en   <= sync_meta;
    end
  end

  always_latch begin
    if (!clk.per_rst_n) en_lat <= 1'b0;
    else if (!raw_clk) en_lat <= sync_en;  // low phase only
  end

  assign gen_clk = clk.testmode ? raw_clk : (raw_clk & en_lat);

endmodule

// File: rcc_per.f
design/rcc_clk_pkg.sv
design/rcc_pwr_pkg.sv
design/rcc_ifs.sv
design/arcg_release_timer.sv
design/per_clk_en_decode.sv
design/bus_clk_gating.sv
design/rst_sync_clk_gating.sv
design/per_ker_clk_rst_control.sv
design/rcc_per_top.sv
bench/tb_clk_gen.sv
bench/tb_rcc_per_top.sv

// File: run.sh
#!/bin/sh
# build and run the RCC peripheral slice testbench with Verilator
# the log is searched for the fail message to set the exit status
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
{ verilator --binary --timing --assert -f rcc_per.f --top-module tb_rcc_per_top \
    -o tb_rcc_per_top && ./obj_dir/tb_rcc_per_top; } > "$LOG" 2>&1 ||
  echo "Test failed" >> "$LOG"
cat "$LOG"
grep -q "Test failed" "$LOG" && exit 1 || exit 0
